// File: list.f
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/inst_decoder.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/rv_core.sv
dv/core_checker.sv
dv/tb_top.sv

// File: Makefile
sim:
	verilator --binary --timing --assert --top-module tb_top -f list.f -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: dv/tb_top.sv
`timescale 1ns/1ps
// Runs 20 random 40-word programs through rv_core with a reset before each
// Data region is 16 words at 0x100 and refilled per run
// Fetches past the program read NOPs
module tb_top;

  localparam int            CLK_PERIOD     = 8;
  localparam int            NUM_RUNS       = 20;
  localparam int            PROG_LEN       = 40;
  localparam int            IMEM_WORDS     = 64;
  localparam int            BODY_END       = PROG_LEN - 8;  // 7 final stores and EBREAK follow
  localparam rv_pkg::word_t DATA_BASE      = 32'h0000_0100;
  localparam int            TIMEOUT_CYCLES = NUM_RUNS * (PROG_LEN * 3 + 30);

  logic          clk = 1'b0;
  logic          rst;
  rv_pkg::word_t instr_addr, instr_data, mem_addr, mem_wdata, mem_rdata;
  logic          mem_read, mem_write, halted, error;
  rv_pkg::word_t imem [0:IMEM_WORDS-1];
  rv_pkg::word_t dmem [0:15];
  int            seed = 49;
  int            mismatches, failures;

  always #(CLK_PERIOD / 2) clk = ~clk;

  rv_core i_dut (
    .clk, .rst, .instr_addr, .instr_data, .mem_addr, .mem_wdata,
    .mem_read, .mem_write, .mem_rdata, .halted, .error
  );

  core_checker i_checker (
    .clk, .rst, .prog(imem), .data_mem(dmem), .data_base(DATA_BASE), .mem_addr,
    .mem_wdata, .mem_read, .mem_write, .halted, .error, .mismatches, .failures
  );

  // Synchronous instruction and data memories with one cycle of read latency
  always @(posedge clk) begin
    instr_data <= (instr_addr < 32'(IMEM_WORDS * 4)) ? imem[instr_addr[7:2]]
                                                     : rv_pkg::NOP_INSTR;
    if (mem_write && mem_addr[31:6] == DATA_BASE[31:6])
      dmem[mem_addr[5:2]] <= mem_wdata;
    if (mem_read)
      mem_rdata <= (mem_addr[31:6] == DATA_BASE[31:6]) ? dmem[mem_addr[5:2]] : '0;
  end

  function automatic int pick(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic rv_pkg::reg_idx_t rnd_reg();
    return rv_pkg::reg_idx_t'(1 + pick(7));  // Only x1..x7 for dense dependencies
  endfunction

  function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
                                           input rv_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                           input rv_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endfunction

  function automatic rv_pkg::word_t i_type(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                           input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
                                           input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_pkg::word_t s_type(input logic [11:0] imm, input rv_pkg::reg_idx_t rs2,
                                           input rv_pkg::reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};  // SW
  endfunction

  function automatic rv_pkg::word_t b_type(input logic [12:0] off, input rv_pkg::reg_idx_t rs2,
                                           input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
  endfunction

  function automatic rv_pkg::word_t u_type(input logic [19:0] imm, input rv_pkg::reg_idx_t rd,
                                           input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic rv_pkg::word_t j_type(input logic [20:0] off, input rv_pkg::reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
  endfunction

  task automatic make_program(input int run);
    int                i;
    int                kind;
    int                k;
    logic [2:0]        f3;
    logic [11:0]       off;
    logic [11:0]       imm;
    rv_pkg::reg_idx_t  rb;
    logic              pair_head [0:PROG_LEN-1];
    for (k = 0; k < IMEM_WORDS; k++)
      imem[k] = rv_pkg::NOP_INSTR;
    for (k = 0; k < PROG_LEN; k++)
      pair_head[k] = 1'b0;
    for (k = 0; k < 16; k++)
      dmem[k] <= ((DATA_BASE + 32'(4 * k)) * 32'h9E37_79B1) ^ 32'(run);
    // x1..x7 get a value first since the register file has no reset
    for (k = 1; k <= 7; k++) begin
      if (pick(2) == 0)
        imem[k-1] = u_type(20'($random(seed)), rv_pkg::reg_idx_t'(k), rv_pkg::OPC_LUI);
      else
        imem[k-1] = i_type(12'($random(seed)), 5'd0, 3'b000, rv_pkg::reg_idx_t'(k),
                           rv_pkg::OPC_OP_IMM);
    end
    i = 7;
    while (i < BODY_END) begin
      kind = pick(16);
      f3   = 3'(pick(8));
      off  = 12'(4 * (2 + pick(3)));  // Skips 1 to 3 words
      if (kind == 15 && i < BODY_END - 1) begin
        rb           = rnd_reg();  // AUIPC base for a JALR relative to it
        imem[i]      = u_type(20'd0, rb, rv_pkg::OPC_AUIPC);
        imem[i+1]    = i_type(off + 12'd4, rb, 3'b000, rnd_reg(), rv_pkg::OPC_JALR);
        pair_head[i] = 1'b1;
        i += 2;
      end else begin
        if (kind < 5)
          imem[i] = r_type(((f3 == 3'b000 || f3 == 3'b101) && pick(2) == 1) ? 7'h20 : 7'h00,
                           rnd_reg(), rnd_reg(), f3, rnd_reg());
        else if (kind == 9)
          imem[i] = u_type(20'($random(seed)), rnd_reg(), rv_pkg::OPC_LUI);
        else if (kind == 10)
          imem[i] = u_type(20'($random(seed)), rnd_reg(), rv_pkg::OPC_AUIPC);
        else if (kind == 11)
          imem[i] = i_type(12'(DATA_BASE) + 12'(4 * pick(16)), 5'd0, 3'b010, rnd_reg(),
                           rv_pkg::OPC_LOAD);
        else if (kind == 12)
          imem[i] = s_type(12'(DATA_BASE) + 12'(4 * pick(16)), rnd_reg(), 5'd0);
        else if (kind == 13) begin
          f3 = 3'(pick(6));
          if (f3 >= 3'd2)
            f3 = f3 + 3'd2;  // 010 and 011 are not branches
          imem[i] = b_type({1'b0, off}, rnd_reg(), rnd_reg(), f3);
        end else if (kind == 14)
          imem[i] = j_type(21'(off), rnd_reg());
        else begin
          if (f3 == 3'b001 || f3 == 3'b101)  // Shifts keep funct7 legal
            imm = {(f3 == 3'b101 && pick(2) == 1) ? 7'h20 : 7'h00, 5'($random(seed))};
          else
            imm = 12'($random(seed));
          imem[i] = i_type(imm, rnd_reg(), f3, rnd_reg(), rv_pkg::OPC_OP_IMM);
        end
        i++;
      end
    end
    for (k = 1; k <= 7; k++)
      imem[BODY_END+k-1] = s_type(12'(DATA_BASE) + 12'(4 * (k + 8)), rv_pkg::reg_idx_t'(k),
                                  5'd0);
    imem[PROG_LEN-1] = rv_pkg::EBREAK_INSTR;
    if (run % 5 == 4) begin
      k = 7 + pick(BODY_END - 7);
      if (pair_head[k])
        k++;  // Keep the JALR base intact
      imem[k] = {25'($random(seed)), 7'b000_1011};  // Custom-0 opcode
    end
  endtask

  initial begin
    rst        <= 1'b1;
    instr_data <= rv_pkg::NOP_INSTR;
    mem_rdata  <= '0;
    for (int run = 0; run < NUM_RUNS; run++) begin
      make_program(run);
      @(posedge clk);
      rst <= 1'b1;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      while (!(halted || error))
        @(posedge clk);
      repeat (4) @(posedge clk);  // Room for any stray strobe
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // Watchdog allows three cycles per instruction plus reset and drain
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the runs did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    $display("Something failed");
    $finish;
  end

endmodule

// File: dv/core_checker.sv
`timescale 1ns/1ps
// Rebuilds the expected store and load lists from the program on every reset cycle
// Stores and loads are compared in order and the end state once halted or error rises
// Model covers the kept RV32I subset and treats any other word as illegal
module core_checker (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t prog [0:63],
  input  rv_pkg::word_t data_mem [0:15],
  input  rv_pkg::word_t data_base,
  input  rv_pkg::word_t mem_addr,
  input  rv_pkg::word_t mem_wdata,
  input  logic          mem_read,
  input  logic          mem_write,
  input  logic          halted,
  input  logic          error,
  output int            mismatches,
  output int            failures
);

  rv_pkg::word_t exp_addr [$];  // Expected stores in program order
  rv_pkg::word_t exp_data [$];
  rv_pkg::word_t exp_load [$];  // Expected load addresses
  logic          exp_halt;      // Low when an illegal word ends the run
  logic          end_seen;
  int            mism_count = 0;
  int            fail_count = 0;

  assign mismatches = mism_count;
  assign failures   = fail_count;

  function automatic rv_pkg::word_t arith(input logic [2:0] f3, input logic alt,
                                          input rv_pkg::word_t a, input rv_pkg::word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'd0);
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic taken(input logic [2:0] f3, input rv_pkg::word_t a,
                                 input rv_pkg::word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;  // BGEU
    endcase
  endfunction

  // One instruction per step in program order
  task automatic run_model();
    rv_pkg::word_t regs [0:31];
    rv_pkg::word_t dmem [0:15];
    rv_pkg::word_t pc, ins, a, b, res, nxt, addr;
    rv_pkg::word_t imm_i, imm_s, imm_b, imm_j;
    logic          wr;
    logic          done;
    int            steps;
    int            k;
    exp_addr.delete();
    exp_data.delete();
    exp_load.delete();
    for (k = 0; k < 32; k++)
      regs[k] = '0;
    for (k = 0; k < 16; k++)
      dmem[k] = data_mem[k];  // Contents as filled for this run
    pc       = rv_pkg::RESET_PC;
    done     = 1'b0;
    exp_halt = 1'b0;
    steps    = 0;
    while (!done && steps < 256) begin
      ins   = (pc < 32'd256) ? prog[pc[7:2]] : 32'h0;  // Off the array counts as illegal
      a     = regs[ins[19:15]];
      b     = regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      res   = '0;
      wr    = 1'b1;
      nxt   = pc + 32'd4;
      case (ins[6:0])
        rv_pkg::OPC_OP_IMM: res = arith(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, imm_i);
        rv_pkg::OPC_OP:     res = arith(ins[14:12], ins[30], a, b);
        rv_pkg::OPC_LUI:    res = {ins[31:12], 12'b0};
        rv_pkg::OPC_AUIPC:  res = pc + {ins[31:12], 12'b0};
        rv_pkg::OPC_JAL: begin
          res = pc + 32'd4;  // Link
          nxt = pc + imm_j;
        end
        rv_pkg::OPC_JALR: begin
          res = pc + 32'd4;
          nxt = (a + imm_i) & ~32'd1;
        end
        rv_pkg::OPC_BRANCH: begin
          wr = 1'b0;
          if (taken(ins[14:12], a, b))
            nxt = pc + imm_b;
        end
        rv_pkg::OPC_LOAD: begin
          addr = a + imm_i;
          exp_load.push_back(addr);
          res  = dmem[4'((addr - data_base) >> 2)];
        end
        rv_pkg::OPC_STORE: begin
          wr   = 1'b0;
          addr = a + imm_s;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
          dmem[4'((addr - data_base) >> 2)] = b;  // Later loads see it
        end
        default: begin
          wr       = 1'b0;
          done     = 1'b1;
          exp_halt = (ins == rv_pkg::EBREAK_INSTR);
        end
      endcase
      if (wr && ins[11:7] != 5'd0)
        regs[ins[11:7]] = res;
      pc = nxt;
      steps++;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      run_model();  // Program and data stay put during reset
      end_seen = 1'b0;
    end else begin
      if (mem_write) begin
        if (exp_addr.size() == 0) begin
          fail_count++;
          $display("%0t: extra store of %h to %h, no store left in the model", $time,
                   mem_wdata, mem_addr);
        end else begin
          if (mem_addr !== exp_addr[0] || mem_wdata !== exp_data[0]) begin
            mism_count++;
            $display("Mismatch at %0t: store of %h to %h, model stores %h to %h", $time,
                     mem_wdata, mem_addr, exp_data[0], exp_addr[0]);
          end
          void'(exp_addr.pop_front());
          void'(exp_data.pop_front());
        end
      end
      if (mem_read) begin
        if (exp_load.size() == 0) begin
          fail_count++;
          $display("%0t: extra load from %h, no load left in the model", $time, mem_addr);
        end else begin
          if (mem_addr !== exp_load[0]) begin
            mism_count++;
            $display("Mismatch at %0t: load from %h, model loads from %h", $time,
                     mem_addr, exp_load[0]);
          end
          void'(exp_load.pop_front());
        end
      end
      // Older stores have drained by the time the flag is seen
      if ((halted || error) && !end_seen) begin
        end_seen = 1'b1;
        if (exp_halt && (!halted || error)) begin
          fail_count++;
          $display("%0t: EBREAK should halt the core, got halted %b error %b", $time,
                   halted, error);
        end
        if (!exp_halt && (!error || halted)) begin
          fail_count++;
          $display("%0t: illegal word should raise error alone, got halted %b error %b",
                   $time, halted, error);
        end
        if (exp_addr.size() != 0) begin
          fail_count++;
          $display("%0t: core stopped with %0d expected stores never seen", $time,
                   exp_addr.size());
        end
        if (exp_load.size() != 0) begin
          fail_count++;
          $display("%0t: core stopped with %0d expected loads never seen", $time,
                   exp_load.size());
        end
      end
    end
  end

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/1ps
// Five-stage RV32I pipeline, branches and jumps resolved in execute
// Fixed-latency memories, instruction word in decode and load data in write-back
// EBREAK or an illegal word freezes fetch, decode and execute until reset
module rv_core (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t instr_addr,
  input  rv_pkg::word_t instr_data,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata,
  output logic          mem_read,
  output logic          mem_write,
  input  rv_pkg::word_t mem_rdata,
  output logic          halted,
  output logic          error
);

  rv_pkg::word_t     pc, fd_pc, d_instr, d_imm, d_rs1_data, d_rs2_data;
  logic              fd_valid;
  rv_pkg::dec_ctrl_t d_ctrl, de_ctrl;
  rv_pkg::reg_idx_t  d_rs1, d_rs2, d_rd, de_rd;
  logic [1:0]        d_fwd_rs1, d_fwd_rs2, de_fwd_rs1, de_fwd_rs2;
  logic              load_stall, flush, redirect, halt_now, hold, e_taken;
  rv_pkg::word_t     de_pc, de_imm, de_rs1_data, de_rs2_data;
  rv_pkg::word_t     e_rs1, e_rs2, e_alu_b, e_alu_res, e_pc_imm, e_result, e_target;
  rv_pkg::ex_mem_t   ex_mem;
  rv_pkg::mem_wb_t   mem_wb;
  rv_pkg::word_t     wb_data;

  function automatic rv_pkg::word_t fwd_pick(input logic [1:0] sel, input rv_pkg::word_t rf_val,
                                             input rv_pkg::word_t mem_val,
                                             input rv_pkg::word_t wb_val);
    case (sel)
      rv_pkg::FWD_MEM: fwd_pick = mem_val;
      rv_pkg::FWD_WB:  fwd_pick = wb_val;
      default:         fwd_pick = rf_val;
    endcase
  endfunction

  // Fetch
  assign halt_now = de_ctrl.valid && (de_ctrl.is_ebreak || de_ctrl.illegal);
  assign hold     = load_stall || halt_now;  // Front end keeps its word
  // Memory read is synchronous, so re-read the decode word while held
  assign instr_addr = hold ? fd_pc : pc;

  always_ff @(posedge clk) begin
    if (redirect) begin
      pc       <= e_target;
      fd_valid <= 1'b0;  // Wrong-path word turns into a bubble
    end else if (!hold) begin
      pc       <= pc + 32'd4;
      fd_valid <= 1'b1;
    end
    if (!hold)
      fd_pc <= pc;
    if (rst) begin
      pc       <= rv_pkg::RESET_PC;
      fd_valid <= 1'b0;
    end
  end

  // Decode
  assign d_instr = fd_valid ? instr_data : rv_pkg::NOP_INSTR;

  inst_decoder i_decoder (
    .instr(d_instr), .instr_valid(fd_valid), .ctrl(d_ctrl), .imm(d_imm),
    .rs1_idx(d_rs1), .rs2_idx(d_rs2), .rd_idx(d_rd)
  );

  reg_file i_regs (
    .clk(clk), .rs1_idx(d_rs1), .rs2_idx(d_rs2), .rd_idx(mem_wb.rd),
    .rd_we(mem_wb.valid && mem_wb.reg_write), .rd_data(wb_data),
    .rs1_data(d_rs1_data), .rs2_data(d_rs2_data)
  );

  hazard_unit i_hazard (
    .rs1_idx(d_rs1), .rs2_idx(d_rs2), .rs1_read(d_ctrl.rs1_read), .rs2_read(d_ctrl.rs2_read),
    .ex_rd(de_rd), .mem_rd(ex_mem.rd), .ex_reg_write(de_ctrl.reg_write),
    .ex_mem_read(de_ctrl.mem_read), .mem_reg_write(ex_mem.reg_write), .redirect(redirect),
    .fwd_rs1(d_fwd_rs1), .fwd_rs2(d_fwd_rs2), .load_stall(load_stall), .flush(flush)
  );

  // Decode to execute, frozen while a halt sits in execute
  always_ff @(posedge clk) begin
    if (!halt_now) begin
      if (flush)
        de_ctrl <= '0;
      else
        de_ctrl <= d_ctrl;
      de_pc       <= fd_pc;
      de_imm      <= d_imm;
      de_rd       <= d_rd;
      de_rs1_data <= d_rs1_data;
      de_rs2_data <= d_rs2_data;
      de_fwd_rs1  <= d_fwd_rs1;
      de_fwd_rs2  <= d_fwd_rs2;
    end
    if (rst)
      de_ctrl <= '0;
  end

  // Execute
  assign e_rs1   = fwd_pick(de_fwd_rs1, de_rs1_data, ex_mem.result, wb_data);
  assign e_rs2   = fwd_pick(de_fwd_rs2, de_rs2_data, ex_mem.result, wb_data);
  assign e_alu_b = de_ctrl.use_imm ? de_imm : e_rs2;

  alu i_alu (
    .op(de_ctrl.alu_op), .a(e_rs1), .b(e_alu_b), .funct3(de_ctrl.funct3),
    .result(e_alu_res), .branch_taken(e_taken)
  );

  assign e_pc_imm = de_pc + de_imm;  // Branch, JAL and AUIPC
  assign e_target = de_ctrl.is_jalr ? {e_alu_res[rv_pkg::XLEN-1:1], 1'b0} : e_pc_imm;
  assign redirect = de_ctrl.valid &&
                    (de_ctrl.is_jal || de_ctrl.is_jalr || (de_ctrl.is_branch && e_taken));

  always_comb begin
    case (de_ctrl.result_sel)
      rv_pkg::RES_PC4:   e_result = de_pc + 32'd4;
      rv_pkg::RES_PCIMM: e_result = e_pc_imm;
      rv_pkg::RES_IMM:   e_result = de_imm;
      default:           e_result = e_alu_res;
    endcase
  end

  always_ff @(posedge clk) begin
    ex_mem.valid      <= de_ctrl.valid && !halt_now;  // EBREAK stays in execute
    ex_mem.reg_write  <= de_ctrl.reg_write;
    ex_mem.mem_read   <= de_ctrl.mem_read;
    ex_mem.mem_write  <= de_ctrl.mem_write;
    ex_mem.rd         <= de_rd;
    ex_mem.result     <= e_result;
    ex_mem.store_data <= e_rs2;
    if (rst) begin
      ex_mem.valid     <= 1'b0;
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_read  <= 1'b0;
      ex_mem.mem_write <= 1'b0;
    end
  end

  // Memory
  assign mem_addr  = {ex_mem.result[rv_pkg::XLEN-1:2], 2'b00};  // Word aligned only
  assign mem_wdata = ex_mem.store_data;
  assign mem_read  = ex_mem.valid && ex_mem.mem_read;
  assign mem_write = ex_mem.valid && ex_mem.mem_write;

  always_ff @(posedge clk) begin
    mem_wb.valid     <= ex_mem.valid;
    mem_wb.reg_write <= ex_mem.reg_write;
    mem_wb.mem_read  <= ex_mem.mem_read;
    mem_wb.rd        <= ex_mem.rd;
    mem_wb.result    <= ex_mem.result;
    if (rst) begin
      mem_wb.valid     <= 1'b0;
      mem_wb.reg_write <= 1'b0;
      mem_wb.mem_read  <= 1'b0;
    end
  end

  // Write-back, load data arrives this cycle
  assign wb_data = mem_wb.mem_read ? mem_rdata : mem_wb.result;

  // Sticky status, one cycle after the stop reaches execute
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
      error  <= 1'b0;
    end else begin
      if (halt_now && de_ctrl.is_ebreak)
        halted <= 1'b1;
      if (halt_now && de_ctrl.illegal)
        error <= 1'b1;
    end
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write));
  // Older stores drain before the flag rises, nothing follows it
  a_quiet_stop: assert property (@(posedge clk) disable iff (rst)
    (halted || error) |-> !(mem_read || mem_write));
  // Decoder hands the ALU only operations it implements
  a_alu_op: assert property (@(posedge clk) disable iff (rst)
    de_ctrl.alu_op inside {[rv_pkg::ALU_ADD:rv_pkg::ALU_AND]});
  // Load moves on to memory, so a stall never repeats
  a_one_bubble: assert property (@(posedge clk) disable iff (rst) load_stall |=> !load_stall);

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps
// Decode-time hazard check, forwarding selects are registered by the core
// Producers are the instructions now in execute and in memory
module hazard_unit (
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  logic             rs1_read,
  input  logic             rs2_read,
  input  rv_pkg::reg_idx_t ex_rd,
  input  rv_pkg::reg_idx_t mem_rd,
  input  logic             ex_reg_write,
  input  logic             ex_mem_read,
  input  logic             mem_reg_write,
  input  logic             redirect,
  output logic [1:0]       fwd_rs1,
  output logic [1:0]       fwd_rs2,
  output logic             load_stall,
  output logic             flush
);

  logic rs1_ex;
  logic rs2_ex;
  logic rs1_mem;
  logic rs2_mem;

  // reg_write is already low for x0 destinations
  assign rs1_ex  = rs1_read && ex_reg_write && (rs1_idx == ex_rd);
  assign rs2_ex  = rs2_read && ex_reg_write && (rs2_idx == ex_rd);
  assign rs1_mem = rs1_read && mem_reg_write && (rs1_idx == mem_rd);
  assign rs2_mem = rs2_read && mem_reg_write && (rs2_idx == mem_rd);

  // One stage later the execute producer sits in memory, the memory one in write-back
  assign fwd_rs1 = rs1_ex ? rv_pkg::FWD_MEM : (rs1_mem ? rv_pkg::FWD_WB : rv_pkg::FWD_REG);
  assign fwd_rs2 = rs2_ex ? rv_pkg::FWD_MEM : (rs2_mem ? rv_pkg::FWD_WB : rv_pkg::FWD_REG);

  assign load_stall = ex_mem_read && (rs1_ex || rs2_ex);  // Load data not back yet
  assign flush      = redirect || load_stall;             // Bubble into execute

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps
// RV32I integer ALU plus branch condition
// Branch compare reuses the subtractor, so branches should carry ALU_SUB
// Shift amount is b[4:0]
module alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  logic [2:0]      funct3,
  output rv_pkg::word_t   result,
  output logic            branch_taken
);

  logic [rv_pkg::XLEN:0] diff;  // Extra bit holds the borrow
  logic [4:0]            shamt;
  logic                  eq;
  logic                  lt_s;
  logic                  lt_u;

  assign diff  = {1'b0, a} - {1'b0, b};
  assign shamt = b[4:0];
  assign eq    = (diff[rv_pkg::XLEN-1:0] == '0);
  assign lt_u  = diff[rv_pkg::XLEN];  // Borrow out
  // Sign bits differ, so a is smaller exactly when it is negative
  assign lt_s  = (a[rv_pkg::XLEN-1] != b[rv_pkg::XLEN-1]) ? a[rv_pkg::XLEN-1]
                                                          : diff[rv_pkg::XLEN-1];

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:  result = a + b;
      rv_pkg::ALU_SUB:  result = diff[rv_pkg::XLEN-1:0];
      rv_pkg::ALU_SLL:  result = a << shamt;
      rv_pkg::ALU_SLT:  result = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
      rv_pkg::ALU_SLTU: result = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
      rv_pkg::ALU_XOR:  result = a ^ b;
      rv_pkg::ALU_SRL:  result = a >> shamt;
      rv_pkg::ALU_SRA:  result = rv_pkg::word_t'($signed(a) >>> shamt);
      rv_pkg::ALU_OR:   result = a | b;
      rv_pkg::ALU_AND:  result = a & b;
      default:          result = '0;
    endcase
  end

  // BEQ BNE BLT BGE BLTU BGEU
  always_comb begin
    case (funct3)
      3'b000:  branch_taken = eq;
      3'b001:  branch_taken = !eq;
      3'b100:  branch_taken = lt_s;
      3'b101:  branch_taken = !lt_s;
      3'b110:  branch_taken = lt_u;
      3'b111:  branch_taken = !lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
// Combinational decode of one RV32I word
// LW and SW are the only memory forms; byte/half, CSR, ECALL and FENCE are illegal
// An illegal word keeps only its illegal flag
module inst_decoder (
  input  rv_pkg::word_t     instr,
  input  logic              instr_valid,
  output rv_pkg::dec_ctrl_t ctrl,
  output rv_pkg::word_t     imm,
  output rv_pkg::reg_idx_t  rs1_idx,
  output rv_pkg::reg_idx_t  rs2_idx,
  output rv_pkg::reg_idx_t  rd_idx
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt;  // funct7 asks for SUB or SRA

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign rd_idx  = instr[11:7];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];
  assign alt     = (funct7 == 7'b010_0000);

  function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  arith_op = sub_sra ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  arith_op = rv_pkg::ALU_SLL;
      3'b010:  arith_op = rv_pkg::ALU_SLT;
      3'b011:  arith_op = rv_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_pkg::ALU_XOR;
      3'b101:  arith_op = sub_sra ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  arith_op = rv_pkg::ALU_OR;
      default: arith_op = rv_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    case (opcode)
      rv_pkg::OPC_STORE:  imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      rv_pkg::OPC_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      rv_pkg::OPC_LUI,
      rv_pkg::OPC_AUIPC:  imm = {instr[31:12], 12'b0};
      rv_pkg::OPC_JAL:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:            imm = {{21{instr[31]}}, instr[30:20]};  // I-type
    endcase
  end

  always_comb begin
    ctrl        = '0;
    ctrl.funct3 = funct3;
    case (opcode)
      rv_pkg::OPC_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.rs1_read  = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.alu_op    = arith_op(funct3, funct3 == 3'b101 && alt);  // No SUBI
        if (funct3 == 3'b001)
          ctrl.illegal = (funct7 != 7'b0);
        else if (funct3 == 3'b101)
          ctrl.illegal = (funct7 != 7'b0) && !alt;
      end
      rv_pkg::OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.rs1_read  = 1'b1;
        ctrl.rs2_read  = 1'b1;
        ctrl.alu_op    = arith_op(funct3, alt);
        ctrl.illegal   = (funct7 != 7'b0) && !(alt && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rv_pkg::OPC_LUI: begin
        ctrl.reg_write  = 1'b1;
        ctrl.result_sel = rv_pkg::RES_IMM;
      end
      rv_pkg::OPC_AUIPC: begin
        ctrl.reg_write  = 1'b1;
        ctrl.result_sel = rv_pkg::RES_PCIMM;
      end
      rv_pkg::OPC_JAL: begin
        ctrl.reg_write  = 1'b1;
        ctrl.is_jal     = 1'b1;
        ctrl.result_sel = rv_pkg::RES_PC4;
      end
      rv_pkg::OPC_JALR: begin
        ctrl.reg_write  = 1'b1;
        ctrl.is_jalr    = 1'b1;
        ctrl.rs1_read   = 1'b1;
        ctrl.use_imm    = 1'b1;  // Target from the ALU adder
        ctrl.result_sel = rv_pkg::RES_PC4;
        ctrl.illegal    = (funct3 != 3'b000);
      end
      rv_pkg::OPC_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.rs1_read  = 1'b1;
        ctrl.rs2_read  = 1'b1;
        ctrl.alu_op    = rv_pkg::ALU_SUB;
        ctrl.illegal   = (funct3[2:1] == 2'b01);  // 010 and 011 unused
      end
      rv_pkg::OPC_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.rs1_read  = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.illegal   = (funct3 != 3'b010);  // LW only
      end
      rv_pkg::OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.rs1_read  = 1'b1;
        ctrl.rs2_read  = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.illegal   = (funct3 != 3'b010);  // SW only
      end
      rv_pkg::OPC_SYSTEM: begin
        ctrl.is_ebreak = (instr == rv_pkg::EBREAK_INSTR);
        ctrl.illegal   = (instr != rv_pkg::EBREAK_INSTR);
      end
      default: ctrl.illegal = 1'b1;
    endcase
    if (ctrl.illegal) begin
      ctrl         = '0;
      ctrl.illegal = 1'b1;
    end
    if (rd_idx == '0)
      ctrl.reg_write = 1'b0;  // Writes to x0 vanish here
    if (!instr_valid)
      ctrl = '0;              // Bubble
    else
      ctrl.valid = 1'b1;
  end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps
// 31 general registers, x0 always reads zero
// Contents are undefined until first written
// A read of the register written in the same cycle returns the new value
module reg_file (
  input  logic             clk,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  rv_pkg::reg_idx_t rd_idx,
  input  logic             rd_we,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  rv_pkg::word_t regs [1:31];  // No storage for x0

  always_ff @(posedge clk) begin
    if (rd_we && rd_idx != '0)
      regs[rd_idx] <= rd_data;
  end

  // Write-through so decode sees the write-back value
  assign rs1_data = (rs1_idx == '0)                  ? '0 :
                    (rd_we && rd_idx == rs1_idx)     ? rd_data :
                                                       regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0)                  ? '0 :
                    (rd_we && rd_idx == rs2_idx)     ? rd_data :
                                                       regs[rs2_idx];

endmodule

// File: rtl/rv_pkg.sv
// Shared widths, opcodes and pipeline structs for the RV32I core
// Fixed to RV32I with word-only loads and stores
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;  // Data, addresses and instructions
  typedef logic [4:0]      reg_idx_t;

  localparam word_t RESET_PC     = 32'h0000_0000;
  localparam word_t NOP_INSTR    = 32'h0000_0013;  // addi x0,x0,0
  localparam word_t EBREAK_INSTR = 32'h0010_0073;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  // Operand source in execute, picked while still in decode
  localparam logic [1:0] FWD_REG = 2'd0;  // Register file read
  localparam logic [1:0] FWD_MEM = 2'd1;  // Result sitting in memory stage
  localparam logic [1:0] FWD_WB  = 2'd2;  // Write-back value, load data included

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {
    RES_ALU,    // ALU output
    RES_PC4,    // Link value
    RES_PCIMM,  // AUIPC
    RES_IMM     // LUI
  } result_sel_e;

  typedef struct packed {
    logic        valid;
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;
    logic        is_ebreak;
    logic        illegal;
    logic        use_imm;   // Second operand is the immediate
    logic        rs1_read;
    logic        rs2_read;
    alu_op_e     alu_op;
    result_sel_e result_sel;
    logic [2:0]  funct3;    // Branch condition
  } dec_ctrl_t;

  typedef struct packed {
    logic     valid;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    reg_idx_t rd;
    word_t    result;      // Also the data address
    word_t    store_data;
  } ex_mem_t;

  typedef struct packed {
    logic     valid;
    logic     reg_write;
    logic     mem_read;    // Take mem_rdata instead of result
    reg_idx_t rd;
    word_t    result;
  } mem_wb_t;

endpackage
